//--- csr_types_pkg.sv
// Machine-mode register layouts for the RV32 CSR file
// Privilege and trap vector mode encodings
// Reset values and read-only constants

`default_nettype none

package csr_types_pkg;

  typedef logic [31:0] csr_word_t;

  typedef enum logic [1:0] {
    U_MODE        = 2'd0,
    S_MODE        = 2'd1,
    RESERVED_MODE = 2'd2,
    M_MODE        = 2'd3
  } priv_level_t;

  typedef enum logic [1:0] {
    DIRECT   = 2'd0,
    VECTORED = 2'd1
  } vector_mode_t;

  // fs, vs, xs and sd fold into the reserved fields, always zero
  typedef struct packed {
    logic [9:0]  reserved_0;
    logic        tw;
    logic [2:0]  reserved_1;
    logic        mprv;
    logic [3:0]  reserved_2;
    priv_level_t mpp;
    logic [2:0]  reserved_3;
    logic        mpie;
    logic [2:0]  reserved_4;
    logic        mie;
    logic [2:0]  reserved_5;
  } mstatus_t;

  typedef struct packed {
    logic [29:0]  base;
    vector_mode_t mode;
  } mtvec_t;

  // Shared by mie and mip
  typedef struct packed {
    logic [19:0] reserved_0;
    logic        external;
    logic [2:0]  reserved_1;
    logic        timer;
    logic [2:0]  reserved_2;
    logic        software;
    logic [2:0]  reserved_3;
  } mint_t;

  // Shared by mcounteren and mcountinhibit
  typedef struct packed {
    logic [28:0] hpm;  // Performance counters, not implemented
    logic        ir;
    logic        tm;
    logic        cy;
  } counter_mask_t;

  // Trap state seen by the trap controller
  typedef struct packed {
    mstatus_t  mstatus;
    mtvec_t    mtvec;
    mint_t     mie;
    mint_t     mip;
    csr_word_t mepc;
    csr_word_t mcause;
  } trap_state_t;

  localparam mstatus_t MSTATUS_RESET = '{
    reserved_0: 10'd0, tw: 1'b1, reserved_1: 3'd0, mprv: 1'b0,
    reserved_2: 4'd0, mpp: U_MODE, reserved_3: 3'd0, mpie: 1'b0,
    reserved_4: 3'd0, mie: 1'b0, reserved_5: 3'd0
  };

  localparam logic [1:0]  MISA_BASE_RV32 = 2'b01;
  localparam logic [25:0] MISA_EXT_I     = 26'h000_0100;
  localparam logic [25:0] MISA_EXT_U     = 26'h010_0000;
  localparam csr_word_t   MISA_VALUE     = {MISA_BASE_RV32, 4'b0000, MISA_EXT_I | MISA_EXT_U};

  localparam csr_word_t     MSTATUSH_VALUE   = 32'h0000_0000;  // Little endian only
  localparam counter_mask_t MCOUNTEREN_RESET = '1;

endpackage

`default_nettype wire

//--- csr_addr_pkg.sv
// CSR addresses and operation codes
// Request and trap injection structs
// Machine identity constants

`default_nettype none

package csr_addr_pkg;

  import csr_types_pkg::*;

  typedef enum logic [11:0] {
    MSTATUS_ADDR       = 12'h300,
    MISA_ADDR          = 12'h301,
    MIE_ADDR           = 12'h304,
    MTVEC_ADDR         = 12'h305,
    MCOUNTEREN_ADDR    = 12'h306,
    MSTATUSH_ADDR      = 12'h310,
    MCOUNTINHIBIT_ADDR = 12'h320,
    MSCRATCH_ADDR      = 12'h340,
    MEPC_ADDR          = 12'h341,
    MCAUSE_ADDR        = 12'h342,
    MTVAL_ADDR         = 12'h343,
    MIP_ADDR           = 12'h344,
    MCYCLE_ADDR        = 12'hB00,
    MINSTRET_ADDR      = 12'hB02,
    MCYCLEH_ADDR       = 12'hB80,
    MINSTRETH_ADDR     = 12'hB82,
    CYCLE_ADDR         = 12'hC00,  // User aliases
    TIME_ADDR          = 12'hC01,
    INSTRET_ADDR       = 12'hC02,
    CYCLEH_ADDR        = 12'hC80,
    TIMEH_ADDR         = 12'hC81,
    INSTRETH_ADDR      = 12'hC82,
    MVENDORID_ADDR     = 12'hF11,
    MARCHID_ADDR       = 12'hF12,
    MIMPID_ADDR        = 12'hF13,
    MHARTID_ADDR       = 12'hF14,
    MCONFIGPTR_ADDR    = 12'hF15
  } csr_addr_t;

  typedef enum logic [1:0] {
    CSR_READ  = 2'd0,
    CSR_WRITE = 2'd1,
    CSR_SET   = 2'd2,
    CSR_CLEAR = 2'd3
  } csr_op_t;

  // Raw address, may name no implemented CSR
  typedef struct packed {
    logic [11:0] addr;
    csr_op_t     op;
    csr_word_t   wdata;
    logic        commit;
  } csr_req_t;

  typedef struct packed {
    logic      inject_mstatus;
    logic      inject_mepc;
    logic      inject_mcause;
    logic      inject_mtval;
    logic      inject_mip;
    mstatus_t  next_mstatus;
    csr_word_t next_mepc;
    csr_word_t next_mcause;
    csr_word_t next_mtval;
    mint_t     next_mip;
  } trap_inj_t;

  localparam csr_word_t VENDOR_ID  = 32'h0000_0000;
  localparam csr_word_t ARCH_ID    = 32'h0000_0000;
  localparam csr_word_t IMPL_ID    = 32'h0000_0000;
  localparam csr_word_t CONFIG_PTR = 32'h0000_0000;

endpackage

`default_nettype wire

//--- csr_access_check.sv
// Legality check of a CSR request
// Read-only, privilege, counter enable and unknown address cases

`default_nettype none

module csr_access_check
  import csr_types_pkg::*, csr_addr_pkg::*;
(
  input  csr_req_t      req,
  input  priv_level_t   priv,
  input  counter_mask_t counteren,
  input  logic          addr_known,
  output logic          illegal
);

  logic modify;
  logic ro_fault;
  logic priv_fault;
  logic cnt_fault;
  logic addr_fault;

  assign modify     = (req.op != CSR_READ);
  assign ro_fault   = modify && (req.addr[11:10] == 2'b11);
  assign priv_fault = modify && (req.addr[9:8] > priv);
  assign addr_fault = modify && !addr_known;

  // User aliases of the counters need mcounteren, reads included
  always_comb begin
    cnt_fault = 1'b0;
    if (priv == U_MODE) begin
      case (csr_addr_t'(req.addr))
        CYCLE_ADDR, CYCLEH_ADDR:     cnt_fault = !counteren.cy;
        TIME_ADDR, TIMEH_ADDR:       cnt_fault = !counteren.tm;
        INSTRET_ADDR, INSTRETH_ADDR: cnt_fault = !counteren.ir;
        default:                     cnt_fault = 1'b0;
      endcase
    end
  end

  assign illegal = ro_fault | priv_fault | cnt_fault | addr_fault;

  // Machine mode may always read what exists
  always_comb begin
    if (priv == M_MODE && req.op == CSR_READ && addr_known) begin
      assert (!illegal)
        else $error("M-mode read of known CSR %h flagged illegal", req.addr);
    end
  end

endmodule

`default_nettype wire

//--- csr_trap_regs.sv
// Machine trap registers and counter controls
// Field legalisation of software writes
// Trap state injection, which wins over a write

`default_nettype none

module csr_trap_regs
  import csr_types_pkg::*, csr_addr_pkg::*;
(
  input  logic          CLK,
  input  logic          nRST,
  input  csr_addr_t     addr,
  input  csr_word_t     wval,
  input  logic          wr_en,
  input  trap_inj_t     inj,
  output trap_state_t   state,
  output csr_word_t     mscratch,
  output csr_word_t     mtval,
  output counter_mask_t counteren,
  output counter_mask_t inhibit
);

  mstatus_t      mstatus, mstatus_next;
  mtvec_t        mtvec, mtvec_next;
  mint_t         mie, mie_next;
  mint_t         mip, mip_next;
  csr_word_t     mepc, mepc_next;
  csr_word_t     mcause, mcause_next;
  csr_word_t     mscratch_next;
  csr_word_t     mtval_next;
  counter_mask_t counteren_next;
  counter_mask_t inhibit_next;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      mstatus   <= MSTATUS_RESET;
      mtvec     <= '0;
      mie       <= '0;
      mip       <= '0;
      mepc      <= '0;
      mcause    <= '0;
      mscratch  <= '0;
      mtval     <= '0;
      counteren <= MCOUNTEREN_RESET;
      inhibit   <= '0;
    end else begin
      mstatus   <= mstatus_next;
      mtvec     <= mtvec_next;
      mie       <= mie_next;
      mip       <= mip_next;
      mepc      <= mepc_next;
      mcause    <= mcause_next;
      mscratch  <= mscratch_next;
      mtval     <= mtval_next;
      counteren <= counteren_next;
      inhibit   <= inhibit_next;
    end
  end

  always_comb begin
    mstatus_next   = mstatus;
    mtvec_next     = mtvec;
    mie_next       = mie;
    mip_next       = mip;
    mepc_next      = mepc;
    mcause_next    = mcause;
    mscratch_next  = mscratch;
    mtval_next     = mtval;
    counteren_next = counteren;
    inhibit_next   = inhibit;

    if (wr_en) begin
      case (addr)
        MSTATUS_ADDR: begin
          mstatus_next      = '0;  // Undefined fields read as zero
          mstatus_next.mie  = wval[3];
          mstatus_next.mpie = wval[7];
          mstatus_next.mprv = wval[17];
          mstatus_next.tw   = wval[21];
          if (wval[12:11] == RESERVED_MODE) begin
            mstatus_next.mpp = U_MODE;
          end else begin
            mstatus_next.mpp = priv_level_t'(wval[12:11]);
          end
        end
        MTVEC_ADDR: begin
          mtvec_next.base = wval[31:2];
          mtvec_next.mode = (wval[1:0] > 2'b01) ? DIRECT : vector_mode_t'(wval[1:0]);
        end
        MIE_ADDR: begin
          mie_next          = '0;
          mie_next.software = wval[3];
          mie_next.timer    = wval[7];
          mie_next.external = wval[11];
        end
        MIP_ADDR: begin
          mip_next          = '0;
          mip_next.software = wval[3];
          mip_next.timer    = wval[7];
          mip_next.external = wval[11];
        end
        MEPC_ADDR:          mepc_next = wval;
        MCAUSE_ADDR:        mcause_next = wval;
        MSCRATCH_ADDR:      mscratch_next = wval;
        MTVAL_ADDR:         mtval_next = wval;
        MCOUNTEREN_ADDR:    counteren_next = counter_mask_t'(wval);
        MCOUNTINHIBIT_ADDR: inhibit_next = counter_mask_t'(wval);
        default: ;
      endcase
    end

    // Trap controller has the last word
    if (inj.inject_mstatus) mstatus_next = inj.next_mstatus;
    if (inj.inject_mepc)    mepc_next = inj.next_mepc;
    if (inj.inject_mcause)  mcause_next = inj.next_mcause;
    if (inj.inject_mtval)   mtval_next = inj.next_mtval;
    if (inj.inject_mip)     mip_next = inj.next_mip;
  end

  assign state.mstatus = mstatus;
  assign state.mtvec   = mtvec;
  assign state.mie     = mie;
  assign state.mip     = mip;
  assign state.mepc    = mepc;
  assign state.mcause  = mcause;

  // Holds across writes and injections alike
  mtvec_mode_legal: assert property (
    @(posedge CLK) disable iff (!nRST) mtvec.mode inside {DIRECT, VECTORED}
  ) else $error("mtvec mode %0d is reserved", mtvec.mode);

endmodule

`default_nettype wire

//--- csr_counters.sv
// 64-bit cycle and retired instruction counters
// Inhibit control and software writes by half

`default_nettype none

module csr_counters
  import csr_types_pkg::*, csr_addr_pkg::*;
(
  input  logic          CLK,
  input  logic          nRST,
  input  csr_addr_t     addr,
  input  csr_word_t     wval,
  input  logic          wr_en,
  input  counter_mask_t inhibit,
  input  logic          inst_ret,
  output logic [63:0]   cycles,
  output logic [63:0]   instret
);

  logic [63:0] cycles_next;
  logic [63:0] instret_next;
  logic        cycle_wr;

  assign cycle_wr = wr_en && (addr == MCYCLE_ADDR || addr == MCYCLEH_ADDR);

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      cycles  <= '0;
      instret <= '0;
    end else begin
      cycles  <= cycles_next;
      instret <= instret_next;
    end
  end

  always_comb begin
    cycles_next  = inhibit.cy ? cycles : cycles + 64'd1;
    instret_next = inhibit.ir ? instret : instret + 64'(inst_ret);

    // The written half replaces the count, no carry into the other
    if (wr_en) begin
      case (addr)
        MCYCLE_ADDR:    cycles_next = {cycles[63:32], wval};
        MCYCLEH_ADDR:   cycles_next = {wval, cycles[31:0]};
        MINSTRET_ADDR:  instret_next = {instret[63:32], wval};
        MINSTRETH_ADDR: instret_next = {wval, instret[31:0]};
        default: ;
      endcase
    end
  end

  cycles_frozen: assert property (
    @(posedge CLK) disable iff (!nRST)
    (inhibit.cy && !cycle_wr) |=> $stable(cycles)
  ) else $error("mcycle moved while inhibited");

endmodule

`default_nettype wire

//--- csr_file.sv
// Top of the machine-mode CSR file
// Write, set and clear merge and write enable
// Combinational read mux with address decode

`default_nettype none

module csr_file
  import csr_types_pkg::*, csr_addr_pkg::*;
#(
  parameter int HART_ID = 0
) (
  input  logic        CLK,
  input  logic        nRST,
  input  logic [63:0] mtime,
  input  csr_req_t    req,
  input  priv_level_t priv,
  input  logic        inst_ret,
  input  trap_inj_t   inj,
  output csr_word_t   rdata,
  output logic        invalid_csr,
  output trap_state_t trap_state
);

  csr_addr_t     addr;
  csr_word_t     old_val;
  csr_word_t     wval;
  logic          wr_en;
  logic          addr_known;
  logic          illegal;
  csr_word_t     mscratch;
  csr_word_t     mtval;
  counter_mask_t counteren;
  counter_mask_t inhibit;
  logic [63:0]   cycles;
  logic [63:0]   instret;

  assign addr = csr_addr_t'(req.addr);

  always_comb begin
    case (req.op)
      CSR_SET:   wval = req.wdata | old_val;
      CSR_CLEAR: wval = old_val & ~req.wdata;
      default:   wval = req.wdata;  // Write, and read for completeness
    endcase
  end

  assign wr_en = req.commit && (req.op != CSR_READ) && !illegal;

  csr_access_check u_check (
    .req        (req),
    .priv       (priv),
    .counteren  (counteren),
    .addr_known (addr_known),
    .illegal    (illegal)
  );

  csr_trap_regs u_trap (
    .CLK       (CLK),
    .nRST      (nRST),
    .addr      (addr),
    .wval      (wval),
    .wr_en     (wr_en),
    .inj       (inj),
    .state     (trap_state),
    .mscratch  (mscratch),
    .mtval     (mtval),
    .counteren (counteren),
    .inhibit   (inhibit)
  );

  csr_counters u_cnt (
    .CLK      (CLK),
    .nRST     (nRST),
    .addr     (addr),
    .wval     (wval),
    .wr_en    (wr_en),
    .inhibit  (inhibit),
    .inst_ret (inst_ret),
    .cycles   (cycles),
    .instret  (instret)
  );

  always_comb begin
    addr_known = 1'b1;
    case (addr)
      MVENDORID_ADDR:     old_val = VENDOR_ID;
      MARCHID_ADDR:       old_val = ARCH_ID;
      MIMPID_ADDR:        old_val = IMPL_ID;
      MHARTID_ADDR:       old_val = csr_word_t'(HART_ID);
      MCONFIGPTR_ADDR:    old_val = CONFIG_PTR;
      MSTATUS_ADDR:       old_val = trap_state.mstatus;
      MISA_ADDR:          old_val = MISA_VALUE;
      MIE_ADDR:           old_val = trap_state.mie;
      MTVEC_ADDR:         old_val = trap_state.mtvec;
      MSTATUSH_ADDR:      old_val = MSTATUSH_VALUE;
      MCOUNTEREN_ADDR:    old_val = counteren;
      MCOUNTINHIBIT_ADDR: old_val = inhibit;
      MSCRATCH_ADDR:      old_val = mscratch;
      MEPC_ADDR:          old_val = trap_state.mepc;
      MCAUSE_ADDR:        old_val = trap_state.mcause;
      MTVAL_ADDR:         old_val = mtval;
      MIP_ADDR:           old_val = trap_state.mip;
      MCYCLE_ADDR, CYCLE_ADDR:       old_val = cycles[31:0];
      MCYCLEH_ADDR, CYCLEH_ADDR:     old_val = cycles[63:32];
      MINSTRET_ADDR, INSTRET_ADDR:   old_val = instret[31:0];
      MINSTRETH_ADDR, INSTRETH_ADDR: old_val = instret[63:32];
      TIME_ADDR:          old_val = mtime[31:0];
      TIMEH_ADDR:         old_val = mtime[63:32];
      default: begin
        old_val    = '0;
        addr_known = 1'b0;
      end
    endcase
  end

  assign rdata       = illegal ? '0 : old_val;
  assign invalid_csr = illegal;

endmodule

`default_nettype wire

//--- tb_csr_file.sv
// Testbench for the machine-mode CSR file
// Reset values, merge and legalisation, access faults, counters,
// counter aliases and trap injection, driven with LFSR data

`default_nettype none

module tb_csr_file
  import csr_types_pkg::*, csr_addr_pkg::*;
();

  localparam int HALF    = 50;
  localparam int SETTLE  = 25;  // Sample point after a falling edge drive
  localparam int MAX_GAP = 32;  // Longest counter wait
  // Six-fold margin over six tests of up to 40 accesses plus three counter gaps
  localparam int TIMEOUT_CYCLES = 6 * (6 * 40 + 3 * MAX_GAP);

  logic        CLK;
  logic        nRST;
  logic [63:0] mtime;
  csr_req_t    req;
  priv_level_t priv;
  logic        inst_ret;
  trap_inj_t   inj;
  csr_word_t   rdata;
  logic        invalid_csr;
  trap_state_t trap_state;

  logic [31:0] lfsr;
  int          checks;
  int          errors;
  int          test_errors;
  int          tests;
  int          cycle_count = 0;

  csr_file #(.HART_ID(5)) DUT (
    .CLK         (CLK),
    .nRST        (nRST),
    .mtime       (mtime),
    .req         (req),
    .priv        (priv),
    .inst_ret    (inst_ret),
    .inj         (inj),
    .rdata       (rdata),
    .invalid_csr (invalid_csr),
    .trap_state  (trap_state)
  );

  initial begin
    CLK = 1'b0;
    forever #HALF CLK = ~CLK;
  end

  always @(posedge CLK) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout: tests still running after %0d cycles", cycle_count);
      $display("TESTS FAILED");
      $finish;
    end
  end

  // An illegal access reads as zero
  zero_on_invalid: assert property (
    @(posedge CLK) disable iff (!nRST) invalid_csr |-> (rdata == '0)
  ) else begin
    errors++;
    $display("ERROR t=%0t rdata got %h expected 00000000 with invalid_csr set",
             $time, $sampled(rdata));
  end

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      v    = {v[30:0], lfsr[0]};
    end
  endtask

  task automatic check_word(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("ERROR t=%0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("ERROR t=%0t %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  // One request, driven on the falling edge and sampled mid low phase
  task automatic access(input logic [11:0] addr, input csr_op_t op,
                        input csr_word_t wdata, input priv_level_t lvl,
                        output csr_word_t rd, output logic inv);
    @(negedge CLK);
    req.addr   = addr;
    req.op     = op;
    req.wdata  = wdata;
    req.commit = (op != CSR_READ);
    priv       = lvl;
    inst_ret   = 1'b0;
    #SETTLE;
    rd  = rdata;
    inv = invalid_csr;
  endtask

  task automatic idle(input logic ret);
    @(negedge CLK);
    req.commit = 1'b0;
    req.op     = CSR_READ;
    inst_ret   = ret;  // Counted at the next rising edge
  endtask

  task automatic expect_read(input string name, input logic [11:0] addr,
                             input priv_level_t lvl, input csr_word_t exp);
    csr_word_t rd;
    logic      inv;
    access(addr, CSR_READ, '0, lvl, rd, inv);
    check_flag({name, " invalid_csr"}, inv, 1'b0);
    check_word(name, rd, exp);
  endtask

  task automatic write_csr(input logic [11:0] addr, input csr_op_t op,
                           input csr_word_t wdata);
    csr_word_t rd;
    logic      inv;
    access(addr, op, wdata, M_MODE, rd, inv);
    check_flag("invalid_csr on M-mode write", inv, 1'b0);
  endtask

  task automatic end_test(input string name);
    tests++;
    $display("Test %0d %s: %s, %0d errors", tests, name,
             (errors == test_errors) ? "ok" : "failed", errors - test_errors);
    test_errors = errors;
  endtask

  initial begin
    csr_word_t   a, b, c, exp, rd, r0, r1;
    logic        inv;
    logic [31:0] v;
    logic [11:0] aliases [3];
    int          n;
    int          ones;

    lfsr        = 32'h5d2374ee;
    checks      = 0;
    errors      = 0;
    test_errors = 0;
    tests       = 0;
    nRST        = 1'b0;
    mtime       = '0;
    req         = '0;
    priv        = M_MODE;
    inst_ret    = 1'b0;
    inj         = '0;
    repeat (4) @(posedge CLK);
    @(negedge CLK);
    nRST = 1'b1;

    expect_read("mstatus", MSTATUS_ADDR, M_MODE, 32'h0020_0000);  // tw only
    expect_read("mcounteren", MCOUNTEREN_ADDR, M_MODE, 32'hFFFF_FFFF);
    expect_read("mvendorid", MVENDORID_ADDR, M_MODE, 32'h0);
    expect_read("marchid", MARCHID_ADDR, M_MODE, 32'h0);
    expect_read("mimpid", MIMPID_ADDR, M_MODE, 32'h0);
    expect_read("mhartid", MHARTID_ADDR, M_MODE, 32'd5);
    expect_read("misa", MISA_ADDR, M_MODE, 32'h4010_0100);  // RV32 with I and U
    check_word("trap_state.mstatus", trap_state.mstatus, 32'h0020_0000);
    check_word("trap_state.mtvec", trap_state.mtvec, 32'h0);
    check_word("trap_state.mie", trap_state.mie, 32'h0);
    check_word("trap_state.mip", trap_state.mip, 32'h0);
    check_word("trap_state.mepc", trap_state.mepc, 32'h0);
    check_word("trap_state.mcause", trap_state.mcause, 32'h0);
    end_test("reset values");

    take_bits(32, a);
    take_bits(32, b);
    take_bits(32, c);
    write_csr(MSCRATCH_ADDR, CSR_WRITE, a);
    expect_read("mscratch after write", MSCRATCH_ADDR, M_MODE, a);
    write_csr(MSCRATCH_ADDR, CSR_SET, b);
    expect_read("mscratch after set", MSCRATCH_ADDR, M_MODE, a | b);
    write_csr(MSCRATCH_ADDR, CSR_CLEAR, c);
    exp = (a | b) & ~c;
    expect_read("mscratch after clear", MSCRATCH_ADDR, M_MODE, exp);
    // mpp of 2 is reserved, top nibble undefined
    write_csr(MSTATUS_ADDR, CSR_WRITE, 32'hF020_1088);
    expect_read("mstatus legalised", MSTATUS_ADDR, M_MODE, 32'h0020_0088);
    write_csr(MTVEC_ADDR, CSR_WRITE, {a[31:2], 2'b10});
    expect_read("mtvec mode 2", MTVEC_ADDR, M_MODE, {a[31:2], 2'b00});
    write_csr(MTVEC_ADDR, CSR_WRITE, {b[31:2], 2'b11});
    expect_read("mtvec mode 3", MTVEC_ADDR, M_MODE, {b[31:2], 2'b00});
    write_csr(MTVEC_ADDR, CSR_WRITE, {c[31:2], 2'b01});
    expect_read("mtvec vectored", MTVEC_ADDR, M_MODE, {c[31:2], 2'b01});
    end_test("merge and legalisation");

    take_bits(32, v);
    access(MSCRATCH_ADDR, CSR_WRITE, v, U_MODE, rd, inv);
    check_flag("invalid_csr on U-mode mscratch write", inv, 1'b1);
    expect_read("mscratch after U-mode write", MSCRATCH_ADDR, M_MODE, exp);
    access(MVENDORID_ADDR, CSR_WRITE, v, M_MODE, rd, inv);
    check_flag("invalid_csr on mvendorid write", inv, 1'b1);
    expect_read("mvendorid after write", MVENDORID_ADDR, M_MODE, 32'h0);
    access(12'h7C0, CSR_WRITE, v, M_MODE, rd, inv);  // No CSR there
    check_flag("invalid_csr on unknown address", inv, 1'b1);
    end_test("access faults");

    take_bits(5, v);
    n = 1 + int'(v[4:0]);
    access(MCYCLE_ADDR, CSR_READ, '0, M_MODE, r0, inv);
    repeat (n - 1) idle(1'b0);
    access(MCYCLE_ADDR, CSR_READ, '0, M_MODE, r1, inv);
    check_word("mcycle delta", r1 - r0, n);
    write_csr(MCOUNTINHIBIT_ADDR, CSR_WRITE, 32'h1);  // cy
    access(MCYCLE_ADDR, CSR_READ, '0, M_MODE, r0, inv);
    repeat (n - 1) idle(1'b0);
    access(MCYCLE_ADDR, CSR_READ, '0, M_MODE, r1, inv);
    check_word("mcycle delta while inhibited", r1 - r0, 32'h0);
    write_csr(MCOUNTINHIBIT_ADDR, CSR_WRITE, 32'h0);
    access(MINSTRET_ADDR, CSR_READ, '0, M_MODE, r0, inv);
    ones = 0;
    for (int i = 0; i < n; i++) begin
      take_bits(1, v);
      ones += int'(v[0]);
      idle(v[0]);
    end
    access(MINSTRET_ADDR, CSR_READ, '0, M_MODE, r1, inv);
    check_word("minstret delta", r1 - r0, ones);
    take_bits(32, v);
    write_csr(MCYCLEH_ADDR, CSR_WRITE, v);
    expect_read("mcycleh after write", MCYCLEH_ADDR, M_MODE, v);
    end_test("counters");

    take_bits(32, a);
    take_bits(32, b);
    @(negedge CLK);
    mtime = {b, a};
    expect_read("time", TIME_ADDR, U_MODE, a);
    expect_read("timeh", TIMEH_ADDR, U_MODE, b);
    write_csr(MCOUNTEREN_ADDR, CSR_WRITE, 32'h0);
    aliases = '{CYCLE_ADDR, INSTRET_ADDR, TIME_ADDR};
    foreach (aliases[i]) begin
      access(aliases[i], CSR_READ, '0, U_MODE, rd, inv);
      check_flag("invalid_csr on disabled U-mode alias", inv, 1'b1);
      check_word("rdata on disabled U-mode alias", rd, 32'h0);
      access(aliases[i], CSR_READ, '0, M_MODE, rd, inv);
      check_flag("invalid_csr on M-mode alias", inv, 1'b0);
    end
    expect_read("time in M mode", TIME_ADDR, M_MODE, a);
    end_test("counter aliases");

    take_bits(32, a);
    take_bits(32, b);
    take_bits(32, c);
    @(negedge CLK);
    req                = '0;
    priv               = M_MODE;
    inj.inject_mepc    = 1'b1;
    inj.next_mepc      = a;
    inj.inject_mcause  = 1'b1;
    inj.next_mcause    = b;
    inj.inject_mstatus = 1'b1;
    inj.next_mstatus   = mstatus_t'(32'h0000_1888);  // mpp M, mpie, mie
    #SETTLE;
    check_word("trap_state.mepc before edge", trap_state.mepc, 32'h0);
    @(negedge CLK);
    inj = '0;
    #SETTLE;
    check_word("trap_state.mepc", trap_state.mepc, a);
    check_word("trap_state.mcause", trap_state.mcause, b);
    check_word("trap_state.mstatus", trap_state.mstatus, 32'h0000_1888);
    @(negedge CLK);
    req.addr        = MEPC_ADDR;
    req.op          = CSR_WRITE;
    req.wdata       = c;
    req.commit      = 1'b1;
    inj.inject_mepc = 1'b1;
    inj.next_mepc   = ~c;
    @(negedge CLK);
    inj        = '0;
    req.commit = 1'b0;
    req.op     = CSR_READ;
    #SETTLE;
    check_word("mepc after write and injection", rdata, ~c);
    check_word("trap_state.mepc after write and injection", trap_state.mepc, ~c);
    end_test("trap injection");

    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- sim.f
csr_types_pkg.sv
csr_addr_pkg.sv
csr_access_check.sv
csr_trap_regs.sv
csr_counters.sv
csr_file.sv
tb_csr_file.sv

//--- Makefile
# Verilator build and run of the CSR file testbench
SIM      = verilator
FLAGS    = --binary --assert --timing -j 0
TOP      = tb_csr_file
FILELIST = sim.f
OBJ_DIR  = obj_dir
LOG      = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "TESTS FAILED" $(LOG); then \
	  echo "Simulation reported failure"; exit 1; \
	fi
	@grep -q "TESTS PASSED" $(LOG) || { echo "Simulation ended without a result"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
